//--- rtl/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

`define LCD_ADDR_W        8         // APB address bits
`define LCD_DATA_W        32        // APB data bits

`define LCD_REG_SCREEN    8'h00     // Screen code
`define LCD_REG_PLATE     8'h04     // Six BCD plate digits
`define LCD_REG_SLOT      8'h08     // Assigned slot number
`define LCD_REG_MINUTES   8'h0C     // Two BCD minute digits
`define LCD_REG_AMOUNT    8'h10     // Two BCD amount digits

`define LCD_CMD_FUNCSET   8'h38     // 8-bit bus, two lines, 5x8 font
`define LCD_CMD_DISPON    8'h0C     // Display on, cursor off
`define LCD_CMD_CLEAR     8'h01     // Clear display, home cursor
`define LCD_CMD_ENTRY     8'h06     // Increment address, no shift
`define LCD_CMD_LINE1     8'h80     // DDRAM address 0x00
`define LCD_CMD_LINE2     8'hC0     // DDRAM address 0x40

`define LCD_SETUP_CYCLES  2         // Data/rs valid before enable rises
`define LCD_EN_CYCLES     4         // Enable pulse width
`define LCD_GAP_CYCLES    4         // Recovery after enable falls
`define LCD_CLEAR_WAIT    40        // Extra idle time after clear

`define LCD_COLS          16        // Characters per line

`endif

//--- rtl/parkingLcdPkg.sv
`default_nettype none

package parkingLcdPkg;

  // Host screen codes, same numbering as the panel firmware
  typedef enum logic [3:0] {
    SCR_WELCOME  = 4'd0,            // Greeting
    SCR_PLATE    = 4'd2,            // Plate entry echo
    SCR_SLOT     = 4'd4,            // Assigned zone and slot
    SCR_THANKS   = 4'd7,            // Goodbye
    SCR_OCCUPIED = 4'd12,           // Lot full
    SCR_TIME     = 4'd15            // Minutes parked and total
  } screenCodeT;

  // Panel sequencer states
  typedef enum logic [2:0] {
    S_INIT,                         // Power-up command list
    S_CLEARWAIT,                    // Settle after clear
    S_LINE1CMD,                     // Cursor to line 1
    S_LINE1CHR,                     // 16 characters of line 1
    S_LINE2CMD,                     // Cursor to line 2
    S_LINE2CHR                      // 16 characters of line 2
  } seqStateT;

  typedef logic [7:0] lcdCharT;     // ASCII byte on the panel bus
  typedef logic [3:0] bcdT;         // One decimal digit
  typedef logic [3:0] colT;         // Column 0..15

endpackage

`default_nettype wire

//--- rtl/apbRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module apbRegs (
  input  wire                        clock50,   // System clock
  input  wire                        rstN,      // Sync reset, active low
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire  [`LCD_ADDR_W-1:0]     paddr,
  input  wire  [`LCD_DATA_W-1:0]     pwdata,
  output logic [`LCD_DATA_W-1:0]     prdata,
  output logic                       pready,
  output logic                       pslverr,
  output parkingLcdPkg::screenCodeT  screen,    // Selected screen
  output logic [23:0]                plate,     // First digit in 23:20
  output parkingLcdPkg::bcdT         slot,
  output logic [7:0]                 minutes,   // Tens in 7:4
  output logic [7:0]                 amount     // Tens in 7:4
);

  logic access;                                 // Access phase of a transfer
  logic mapped;                                 // Address hits a register
  logic wrEn;

  assign access  = psel && penable;
  assign wrEn    = access && pwrite && mapped;
  assign pready  = 1'b1;                        // No wait states
  assign pslverr = access && !mapped;           // Unmapped read or write

  always_comb begin
    case (paddr)
      `LCD_REG_SCREEN, `LCD_REG_PLATE, `LCD_REG_SLOT,
      `LCD_REG_MINUTES, `LCD_REG_AMOUNT: mapped = 1'b1;
      default:                           mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clock50) begin
    if (!rstN) begin
      screen  <= parkingLcdPkg::SCR_WELCOME;   // Greeting after reset
      plate   <= '0;
      slot    <= '0;
      minutes <= '0;
      amount  <= '0;
    end else if (wrEn) begin
      case (paddr)
        `LCD_REG_SCREEN:  screen  <= parkingLcdPkg::screenCodeT'(pwdata[3:0]);
        `LCD_REG_PLATE:   plate   <= pwdata[23:0];
        `LCD_REG_SLOT:    slot    <= pwdata[3:0];
        `LCD_REG_MINUTES: minutes <= pwdata[7:0];
        `LCD_REG_AMOUNT:  amount  <= pwdata[7:0];
        default:          ;                    // Blocked by wrEn
      endcase
    end
  end

  // Read mux, zero-extended fields
  always_comb begin
    prdata = '0;
    case (paddr)
      `LCD_REG_SCREEN:  prdata[3:0]  = screen;
      `LCD_REG_PLATE:   prdata[23:0] = plate;
      `LCD_REG_SLOT:    prdata[3:0]  = slot;
      `LCD_REG_MINUTES: prdata[7:0]  = minutes;
      `LCD_REG_AMOUNT:  prdata[7:0]  = amount;
      default:          prdata       = '0;     // Error response reads zero
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/screenComposer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module screenComposer (
  input  wire                              clock50,
  input  wire                              rstN,
  input  wire                              frameStart,  // Snapshot strobe
  input  wire parkingLcdPkg::screenCodeT   screen,
  input  wire [23:0]                       plate,
  input  wire parkingLcdPkg::bcdT          slot,
  input  wire [7:0]                        minutes,
  input  wire [7:0]                        amount,
  input  wire                              line,        // 0 top, 1 bottom
  input  wire parkingLcdPkg::colT          col,
  output parkingLcdPkg::lcdCharT           lcdChar
);

  // Fixed text, '#' marks a live field
  localparam logic [8*`LCD_COLS-1:0] welcomeL1  = "  BIENVENIDOS   ";
  localparam logic [8*`LCD_COLS-1:0] welcomeL2  = "   UN PARKING   ";
  localparam logic [8*`LCD_COLS-1:0] plateL1    = "INGRESE SU PLACA";
  localparam logic [8*`LCD_COLS-1:0] plateL2    = "---->######<----";
  localparam logic [8*`LCD_COLS-1:0] slotL1     = " SU PARQUEADERO ";
  localparam logic [8*`LCD_COLS-1:0] slotL2     = "ASIGNADO>>>Z#-P#";
  localparam logic [8*`LCD_COLS-1:0] thanksL1   = "  GRACIAS POR   ";
  localparam logic [8*`LCD_COLS-1:0] thanksL2   = "   SU VISITA!   ";
  localparam logic [8*`LCD_COLS-1:0] occupiedL1 = "  PARQUEADERO   ";
  localparam logic [8*`LCD_COLS-1:0] occupiedL2 = "    OCUPADO     ";
  localparam logic [8*`LCD_COLS-1:0] timeL1     = "TIEMPO ==> ##MIN";
  localparam logic [8*`LCD_COLS-1:0] timeL2     = "TOTAL  ==> $##  ";

  parkingLcdPkg::screenCodeT snapScreen;     // Frozen for one frame
  logic [23:0]               snapPlate;
  parkingLcdPkg::bcdT        snapSlot;
  logic [7:0]                snapMinutes;
  logic [7:0]                snapAmount;
  logic [8*`LCD_COLS-1:0]    text1;
  logic [8*`LCD_COLS-1:0]    text2;
  logic [23:0]               plateShifted;   // Current plate digit on top

  function automatic parkingLcdPkg::lcdCharT bcdChar(input parkingLcdPkg::bcdT d);
    if (d > 4'd9)
      return "?";                            // Not a decimal digit
    return 8'h30 + {4'h0, d};
  endfunction

  // Slot to zone, two slots per zone
  function automatic parkingLcdPkg::lcdCharT zoneChar(input parkingLcdPkg::bcdT s);
    case (s)
      4'd0:       return "0";
      4'd1, 4'd2: return "1";
      4'd3, 4'd4: return "2";
      4'd5, 4'd6: return "3";
      default:    return "?";
    endcase
  endfunction

  function automatic parkingLcdPkg::lcdCharT pickChar(input logic [8*`LCD_COLS-1:0] txt,
                                                      input parkingLcdPkg::colT c);
    return txt[8*(`LCD_COLS - 1 - c) +: 8];  // Leftmost character in the MSBs
  endfunction

  always_ff @(posedge clock50) begin
    if (!rstN) begin
      snapScreen  <= parkingLcdPkg::SCR_WELCOME;
      snapPlate   <= '0;
      snapSlot    <= '0;
      snapMinutes <= '0;
      snapAmount  <= '0;
    end else if (frameStart) begin
      snapScreen  <= screen;
      snapPlate   <= plate;
      snapSlot    <= slot;
      snapMinutes <= minutes;
      snapAmount  <= amount;
    end
  end

  assign plateShifted = snapPlate << (4 * (col - 4'd5));  // Column 5 is digit 1

  always_comb begin
    case (snapScreen)
      parkingLcdPkg::SCR_PLATE:    begin text1 = plateL1;    text2 = plateL2;    end
      parkingLcdPkg::SCR_SLOT:     begin text1 = slotL1;     text2 = slotL2;     end
      parkingLcdPkg::SCR_THANKS:   begin text1 = thanksL1;   text2 = thanksL2;   end
      parkingLcdPkg::SCR_OCCUPIED: begin text1 = occupiedL1; text2 = occupiedL2; end
      parkingLcdPkg::SCR_TIME:     begin text1 = timeL1;     text2 = timeL2;     end
      default:                     begin text1 = welcomeL1;  text2 = welcomeL2;  end
    endcase
  end

  // Base text, then live fields on top
  always_comb begin
    lcdChar = pickChar(line ? text2 : text1, col);
    case (snapScreen)
      parkingLcdPkg::SCR_PLATE: begin
        if (line && col >= 4'd5 && col <= 4'd10)
          lcdChar = bcdChar(plateShifted[23:20]);
      end
      parkingLcdPkg::SCR_SLOT: begin
        if (line && col == 4'd12)
          lcdChar = zoneChar(snapSlot);
        else if (line && col == 4'd15)
          lcdChar = bcdChar(snapSlot);
      end
      parkingLcdPkg::SCR_TIME: begin
        if (!line && col == 4'd11)
          lcdChar = bcdChar(snapMinutes[7:4]);
        else if (!line && col == 4'd12)
          lcdChar = bcdChar(snapMinutes[3:0]);
        else if (line && col == 4'd12)
          lcdChar = bcdChar(snapAmount[7:4]);
        else if (line && col == 4'd13)
          lcdChar = bcdChar(snapAmount[3:0]);
      end
      default: ;                             // Fixed text only
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/lcdSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module lcdSequencer (
  input  wire                            clock50,
  input  wire                            rstN,
  input  wire                            busy,        // Driver mid-write
  input  wire parkingLcdPkg::lcdCharT    lcdChar,     // Composer output
  output logic                           frameStart,  // Pulse with LINE1 request
  output logic                           line,
  output parkingLcdPkg::colT             col,
  output logic                           writeReq,
  output logic                           writeRs,     // 0 command, 1 data
  output parkingLcdPkg::lcdCharT         writeByte
);

  localparam int waitW = $clog2(`LCD_CLEAR_WAIT + 1);
  localparam parkingLcdPkg::colT lastCol = parkingLcdPkg::colT'(`LCD_COLS - 1);
  localparam logic [waitW-1:0] waitLast = waitW'(`LCD_CLEAR_WAIT - 1);

  parkingLcdPkg::seqStateT state;
  logic [1:0]              initStep;                  // Which init command next
  logic [waitW-1:0]        waitCnt;                   // Idle cycles after clear
  logic                    canIssue;
  parkingLcdPkg::lcdCharT  initCmd;

  // Request in flight keeps busy low one more cycle
  assign canIssue = !busy && !writeReq;

  always_comb begin
    case (initStep)
      2'd0:    initCmd = `LCD_CMD_FUNCSET;
      2'd1:    initCmd = `LCD_CMD_DISPON;
      2'd2:    initCmd = `LCD_CMD_CLEAR;
      default: initCmd = `LCD_CMD_ENTRY;
    endcase
  end

  always_ff @(posedge clock50) begin
    if (!rstN) begin
      state      <= parkingLcdPkg::S_INIT;
      initStep   <= '0;
      waitCnt    <= '0;
      line       <= 1'b0;
      col        <= '0;
      writeReq   <= 1'b0;
      frameStart <= 1'b0;
      writeRs    <= 1'b0;
      writeByte  <= '0;
    end else begin
      writeReq   <= 1'b0;                             // Single-cycle strobes
      frameStart <= 1'b0;
      case (state)
        parkingLcdPkg::S_INIT: begin
          if (canIssue) begin
            writeReq  <= 1'b1;
            writeRs   <= 1'b0;
            writeByte <= initCmd;
            initStep  <= initStep + 2'd1;
            if (initStep == 2'd2)
              state <= parkingLcdPkg::S_CLEARWAIT;    // Clear is slow on the panel
            else if (initStep == 2'd3)
              state <= parkingLcdPkg::S_LINE1CMD;
          end
        end
        parkingLcdPkg::S_CLEARWAIT: begin
          if (canIssue) begin                         // Count only after clear ends
            if (waitCnt == waitLast) begin
              waitCnt <= '0;
              state   <= parkingLcdPkg::S_INIT;       // Entry mode still to send
            end else begin
              waitCnt <= waitCnt + 1'b1;
            end
          end
        end
        parkingLcdPkg::S_LINE1CMD: begin
          if (canIssue) begin
            writeReq   <= 1'b1;
            writeRs    <= 1'b0;
            writeByte  <= `LCD_CMD_LINE1;
            frameStart <= 1'b1;                       // Composer freezes fields
            line       <= 1'b0;
            col        <= '0;
            state      <= parkingLcdPkg::S_LINE1CHR;
          end
        end
        parkingLcdPkg::S_LINE1CHR: begin
          if (canIssue) begin
            writeReq  <= 1'b1;
            writeRs   <= 1'b1;
            writeByte <= lcdChar;
            col       <= col + 4'd1;                  // Wraps to 0 after last
            if (col == lastCol)
              state <= parkingLcdPkg::S_LINE2CMD;
          end
        end
        parkingLcdPkg::S_LINE2CMD: begin
          if (canIssue) begin
            writeReq  <= 1'b1;
            writeRs   <= 1'b0;
            writeByte <= `LCD_CMD_LINE2;
            line      <= 1'b1;
            col       <= '0;
            state     <= parkingLcdPkg::S_LINE2CHR;
          end
        end
        parkingLcdPkg::S_LINE2CHR: begin
          if (canIssue) begin
            writeReq  <= 1'b1;
            writeRs   <= 1'b1;
            writeByte <= lcdChar;
            col       <= col + 4'd1;
            if (col == lastCol)
              state <= parkingLcdPkg::S_LINE1CMD;     // Next frame
          end
        end
        default: state <= parkingLcdPkg::S_INIT;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/lcdBusDriver.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module lcdBusDriver (
  input  wire                            clock50,
  input  wire                            rstN,
  input  wire                            writeReq,   // One-cycle request
  input  wire                            writeRs,
  input  wire parkingLcdPkg::lcdCharT    writeByte,
  output logic                           busy,
  output parkingLcdPkg::lcdCharT         lcdData,
  output logic                           lcdRs,
  output logic                           lcdEn
);

  localparam int phaseEnd = `LCD_SETUP_CYCLES + `LCD_EN_CYCLES + `LCD_GAP_CYCLES;
  localparam int phaseW   = $clog2(phaseEnd + 1);
  localparam logic [phaseW-1:0] enOnAt  = phaseW'(`LCD_SETUP_CYCLES - 1);
  localparam logic [phaseW-1:0] enOffAt = phaseW'(`LCD_SETUP_CYCLES + `LCD_EN_CYCLES - 1);
  localparam logic [phaseW-1:0] doneAt  = phaseW'(phaseEnd - 1);

  logic [phaseW-1:0] phase;                          // Cycles since latch
  logic              start;

  assign start = writeReq && !busy;

  always_ff @(posedge clock50) begin
    if (!rstN) begin
      busy  <= 1'b0;
      lcdEn <= 1'b0;
      phase <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      phase <= '0;
    end else if (busy) begin
      phase <= phase + 1'b1;
      if (phase == enOnAt)
        lcdEn <= 1'b1;                               // Setup done
      if (phase == enOffAt)
        lcdEn <= 1'b0;                               // Panel latches on this fall
      if (phase == doneAt)
        busy <= 1'b0;                                // Gap over
    end
  end

  // Held steady for the whole write
  always_ff @(posedge clock50) begin
    if (start) begin
      lcdData <= writeByte;
      lcdRs   <= writeRs;
    end
  end

endmodule

`default_nettype wire

//--- rtl/parkingLcdTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module parkingLcdTop (
  input  wire                         clock50,   // 50 MHz board clock
  input  wire                         rstN,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire  [`LCD_ADDR_W-1:0]      paddr,
  input  wire  [`LCD_DATA_W-1:0]      pwdata,
  output logic [`LCD_DATA_W-1:0]      prdata,
  output logic                        pready,
  output logic                        pslverr,
  output parkingLcdPkg::lcdCharT      lcdData,   // Panel D7..D0
  output logic                        lcdRs,
  output logic                        lcdEn
);

  parkingLcdPkg::screenCodeT screen;
  logic [23:0]               plate;
  parkingLcdPkg::bcdT        slot;
  logic [7:0]                minutes;
  logic [7:0]                amount;
  logic                      frameStart;
  logic                      line;
  parkingLcdPkg::colT        col;
  parkingLcdPkg::lcdCharT    lcdChar;            // Composer to sequencer
  logic                      writeReq;
  logic                      writeRs;
  parkingLcdPkg::lcdCharT    writeByte;
  logic                      busy;

  apbRegs regs0 (
    .clock50(clock50), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .screen(screen), .plate(plate), .slot(slot), .minutes(minutes), .amount(amount)
  );

  screenComposer composer0 (
    .clock50(clock50), .rstN(rstN), .frameStart(frameStart), .screen(screen),
    .plate(plate), .slot(slot), .minutes(minutes), .amount(amount),
    .line(line), .col(col), .lcdChar(lcdChar)
  );

  lcdSequencer sequencer0 (
    .clock50(clock50), .rstN(rstN), .busy(busy), .lcdChar(lcdChar),
    .frameStart(frameStart), .line(line), .col(col), .writeReq(writeReq),
    .writeRs(writeRs), .writeByte(writeByte)
  );

  lcdBusDriver driver0 (
    .clock50(clock50), .rstN(rstN), .writeReq(writeReq), .writeRs(writeRs),
    .writeByte(writeByte), .busy(busy), .lcdData(lcdData), .lcdRs(lcdRs), .lcdEn(lcdEn)
  );

endmodule

`default_nettype wire

//--- testbench/parkingLcd_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module parkingLcdAssertions (
  input wire       clock50,
  input wire       rstN,
  input wire       psel,
  input wire       penable,
  input wire       pslverr,
  input wire [7:0] lcdData,
  input wire       lcdRs,
  input wire       lcdEn
);

  int enCnt;                                            // Cycles lcdEn has been high

  always_ff @(posedge clock50) begin
    if (!rstN)
      enCnt <= 0;
    else if (lcdEn)
      enCnt <= enCnt + 1;
    else
      enCnt <= 0;
  end

  aEnWidth: assert property (@(posedge clock50) disable iff (!rstN)
    $fell(lcdEn) |-> enCnt == `LCD_EN_CYCLES)
    else $error("lcdEn pulse width differs from LCD_EN_CYCLES");

  aBusStable: assert property (@(posedge clock50) disable iff (!rstN)
    lcdEn |-> $stable(lcdData) && $stable(lcdRs))
    else $error("lcdData or lcdRs changed while lcdEn high");

  aEnReset: assert property (@(posedge clock50) !rstN |=> !lcdEn)
    else $error("lcdEn high during reset");

  aErrAccess: assert property (@(posedge clock50) disable iff (!rstN)
    pslverr |-> psel && penable)
    else $error("pslverr outside an access phase");

endmodule

`default_nettype wire

//--- testbench/parkingLcdTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lcd_cfg.svh"

module parkingLcdTb;

  localparam int period      = 8;                       // ns
  localparam int numTests    = 11;                      // Records in the pattern file
  localparam int recWords    = 7;                       // Five registers, two text lines
  localparam int writeCycles = `LCD_SETUP_CYCLES + `LCD_EN_CYCLES + `LCD_GAP_CYCLES + 2;
  localparam int initCycles  = 4 * writeCycles + `LCD_CLEAR_WAIT;
  localparam int limitCycles = ((numTests + 3) * 34 * writeCycles + initCycles) * 2;
  localparam time snapOffset = (`LCD_SETUP_CYCLES + `LCD_EN_CYCLES) * period;  // Snapshot to fall
  localparam logic [7:0] regAddr [5] = '{`LCD_REG_SCREEN, `LCD_REG_PLATE, `LCD_REG_SLOT,
                                         `LCD_REG_MINUTES, `LCD_REG_AMOUNT};
  localparam logic [31:0] regMask [5] = '{32'h0000000F, 32'h00FFFFFF, 32'h0000000F,
                                          32'h000000FF, 32'h000000FF};

  logic                          clock50;
  logic                          rstN;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`LCD_ADDR_W-1:0]        paddr;
  logic [`LCD_DATA_W-1:0]        pwdata;
  logic [`LCD_DATA_W-1:0]        prdata;
  logic                          pready;
  logic                          pslverr;
  parkingLcdPkg::lcdCharT        lcdData;
  logic                          lcdRs;
  logic                          lcdEn;

  logic [127:0] patMem [0:numTests*recWords-1];         // Registers, then line 1 and 2
  logic [8:0]   wrQ [$];                                // Seen writes as {rs, byte}
  time          wrTime [$];                             // Fall time of each enable pulse
  int           checkCount;
  int           errCount;
  int           seed;

  parkingLcdTop dut0 (
    .clock50(clock50), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .lcdData(lcdData), .lcdRs(lcdRs), .lcdEn(lcdEn)
  );

  bind parkingLcdTop parkingLcdAssertions asrt0 (
    .clock50(clock50), .rstN(rstN), .psel(psel), .penable(penable), .pslverr(pslverr),
    .lcdData(lcdData), .lcdRs(lcdRs), .lcdEn(lcdEn)
  );

  initial begin
    clock50 = 1'b0;
    forever #(period / 2) clock50 = ~clock50;
  end

  // Panel latches on the falling enable
  always @(negedge lcdEn) begin
    if (rstN === 1'b1) begin
      wrQ.push_back({lcdRs, lcdData});
      wrTime.push_back($time);
    end
  end

  initial begin
    #(limitCycles * period);
    $display("Timeout after %0d cycles, the LCD bus stopped delivering writes", limitCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic checkChar(input parkingLcdPkg::lcdCharT got, input logic gotRs,
                           input parkingLcdPkg::lcdCharT exp, input string what);
    checkCount++;
    if (got !== exp || gotRs !== 1'b1) begin
      errCount++;
      $display("CHECK FAILED at %0t: %s char expected %h rs 1, got %h rs %b",
               $time, what, exp, got, gotRs);
    end
  endtask

  task automatic checkCmd(input parkingLcdPkg::lcdCharT got, input logic gotRs,
                          input parkingLcdPkg::lcdCharT exp, input string what);
    checkCount++;
    if (got !== exp || gotRs !== 1'b0) begin
      errCount++;
      $display("CHECK FAILED at %0t: %s command expected %h rs 0, got %h rs %b",
               $time, what, exp, got, gotRs);
    end
  endtask

  task automatic checkReg(input logic [`LCD_DATA_W-1:0] got,
                          input logic [`LCD_DATA_W-1:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic checkErr(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED at %0t: %s pslverr expected %b, got %b", $time, what, exp, got);
    end
  endtask

  // No wait states on this slave
  task automatic checkReady(input logic got, input string what);
    checkCount++;
    if (got !== 1'b1) begin
      errCount++;
      $display("CHECK FAILED at %0t: %s pready expected 1, got %b", $time, what, got);
    end
  endtask

  task automatic popWrite(output logic rs, output parkingLcdPkg::lcdCharT b, output time t);
    logic [8:0] w;
    while (wrQ.size() == 0)
      @(posedge clock50);
    w  = wrQ.pop_front();
    t  = wrTime.pop_front();
    rs = w[8];
    b  = w[7:0];
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
                          output logic err, output time tAcc);
    @(posedge clock50);
    #1;
    psel    = 1'b1;                                     // Setup phase
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clock50);
    #1 penable = 1'b1;                                  // Access phase
    @(negedge clock50);
    err = pslverr;
    checkReady(pready, $sformatf("write 0x%h", addr));
    @(posedge clock50);
    tAcc = $time;                                       // Write lands on this edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clock50);
    #1;
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clock50);
    #1 penable = 1'b1;
    @(negedge clock50);
    data = prdata;                                      // Settled mid-cycle
    err  = pslverr;
    checkReady(pready, $sformatf("read 0x%h", addr));
    @(posedge clock50);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Skips writes until a LINE1 whose snapshot edge follows tw
  task automatic waitLine1After(input time tw);
    logic                   rs;
    parkingLcdPkg::lcdCharT b;
    time                    t;
    bit                     found;
    found = 1'b0;
    while (!found) begin
      popWrite(rs, b, t);
      if (rs == 1'b0 && b == `LCD_CMD_LINE1 && t - snapOffset > tw)
        found = 1'b1;
    end
  endtask

  // LINE1 already consumed
  task automatic readFrame(input logic [127:0] exp1, input logic [127:0] exp2, input string tag);
    logic                   rs;
    parkingLcdPkg::lcdCharT b;
    time                    t;
    for (int c = 0; c < `LCD_COLS; c++) begin
      popWrite(rs, b, t);
      checkChar(b, rs, exp1[8*(`LCD_COLS-1-c) +: 8], $sformatf("%s line 1 col %0d", tag, c));
    end
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_LINE2, {tag, " line 2 address"});
    for (int c = 0; c < `LCD_COLS; c++) begin
      popWrite(rs, b, t);
      checkChar(b, rs, exp2[8*(`LCD_COLS-1-c) +: 8], $sformatf("%s line 2 col %0d", tag, c));
    end
  endtask

  initial begin
    logic                   rs;
    parkingLcdPkg::lcdCharT b;
    time                    t;
    time                    tw;
    logic                   err;
    logic [31:0]            rd;
    logic [31:0]            v;
    int                     base;
    rstN       = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    checkCount = 0;
    errCount   = 0;
    seed       = 32'h29a01920;
    $readmemh("testbench/parkingLcd_patterns.hex", patMem);
    if ($isunknown(patMem[5]) || patMem[5] === '0) begin
      errCount++;
      $display("Pattern file testbench/parkingLcd_patterns.hex is missing or empty");
    end
    repeat (2) @(posedge clock50);
    #1 rstN = 1'b1;

    // Power-up command list, then the welcome frame
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_FUNCSET, "init 1");
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_DISPON, "init 2");
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_CLEAR, "init 3");
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_ENTRY, "init 4");
    popWrite(rs, b, t);
    checkCmd(b, rs, `LCD_CMD_LINE1, "first line 1 address");
    readFrame(patMem[5], patMem[6], "power-up frame");

    for (int r = 0; r < numTests; r++) begin
      base = r * recWords;
      for (int k = 0; k < 5; k++) begin
        apbWrite(regAddr[k], patMem[base+k][31:0], err, tw);
        checkErr(err, 1'b0, $sformatf("record %0d register %0d write", r, k));
      end
      waitLine1After(tw);
      readFrame(patMem[base+5], patMem[base+6], $sformatf("record %0d", r));
    end

    // Unmapped accesses where 0x20 would alias SCREEN under a partial decode
    apbWrite(8'h20, 32'h0000000F, err, tw);
    checkErr(err, 1'b1, "unmapped write 0x20");
    apbRead(8'h14, rd, err);
    checkErr(err, 1'b1, "unmapped read 0x14");
    apbWrite(8'h02, 32'h00000004, err, tw);
    checkErr(err, 1'b1, "unmapped write 0x02");
    waitLine1After(tw);
    base = (numTests - 1) * recWords;
    readFrame(patMem[base+5], patMem[base+6], "after unmapped access");

    // Random read-back
    for (int k = 0; k < 5; k++) begin
      v = $random(seed);
      apbWrite(regAddr[k], v, err, tw);
      checkErr(err, 1'b0, $sformatf("random write register %0d", k));
      apbRead(regAddr[k], rd, err);
      checkErr(err, 1'b0, $sformatf("read-back register %0d", k));
      checkReg(rd, v & regMask[k], $sformatf("read-back register %0d", k));
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/parkingLcd_patterns.hex
// screen plate slot minutes amount, then expected line 1 and line 2 (16 ASCII bytes each)
// one record per line, leftmost character in the most significant byte
0 000000 0 00 00 20204249454E56454E49444F53202020 202020554E205041524B494E47202020
2 123456 0 00 00 494E475245534520535520504C414341 2D2D2D2D3E3132333435363C2D2D2D2D
4 123456 0 00 00 20535520504152515545414445524F20 415349474E41444F3E3E3E5A302D5030
4 123456 2 00 00 20535520504152515545414445524F20 415349474E41444F3E3E3E5A312D5032
4 123456 3 00 00 20535520504152515545414445524F20 415349474E41444F3E3E3E5A322D5033
4 123456 6 00 00 20535520504152515545414445524F20 415349474E41444F3E3E3E5A332D5036
4 123456 8 00 00 20535520504152515545414445524F20 415349474E41444F3E3E3E5A3F2D5038
7 000000 0 00 00 20204752414349415320504F52202020 20202053552056495349544121202020
C 000000 0 00 00 2020504152515545414445524F202020 202020204F43555041444F2020202020
F 000000 0 45 3A 5449454D504F203D3D3E2034354D494E 544F54414C20203D3D3E2024333F2020
9 000000 0 45 3A 20204249454E56454E49444F53202020 202020554E205041524B494E47202020

//--- files.f
+incdir+rtl
rtl/parkingLcdPkg.sv
rtl/apbRegs.sv
rtl/screenComposer.sv
rtl/lcdSequencer.sv
rtl/lcdBusDriver.sv
rtl/parkingLcdTop.sv
testbench/parkingLcd_assertions.sv
testbench/parkingLcdTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module parkingLcdTb -f files.f -o parkingLcdSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/parkingLcdSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
